// File: design/rx_frame_if.sv
`timescale 1ns/1ns

// Carries one received frame from the receiver to the FIFO and the top level
interface rx_frame_if #(
    parameter int DATA_BITS = 8
) ();

    logic [DATA_BITS-1:0] data;  // Received byte, valid from frame_done until the next frame_done
    logic data_rdy;              // One-cycle strobe, only for a frame without errors
    logic [2:0] rx_error;        // Error flags of the last frame, held between frames
    logic frame_done;            // One-cycle strobe at the end of every frame, good or bad

    // Receiver side
    modport src (
        output data,
        output data_rdy,
        output rx_error,
        output frame_done
    );

    // FIFO and top level side
    modport snk (
        input data,
        input data_rdy,
        input rx_error,
        input frame_done
    );

endinterface

// File: design/uart_baud_tick.sv
`timescale 1ns/1ns

module uart_baud_tick import uart_pkg::*; #(
    parameter int CLK_FREQ = 3_200_000,
    parameter int BAUD_RATE = 100_000
) (
    input  logic Clk,
    input  logic Rst,
    output logic tick
);

    // Clocks per oversampling tick
    localparam int DIV = CLK_FREQ / (OVERSAMPLE * BAUD_RATE);
    localparam int CNT_W = (DIV > 1) ? $clog2(DIV) : 1;
    localparam logic [CNT_W-1:0] LAST = CNT_W'(DIV - 1);  // Terminal count of the divider

    logic [CNT_W-1:0] cnt;

    // Free-running divider, tick is registered so it stays clean and low in reset
    always_ff @(posedge Clk or posedge Rst) begin
        if (Rst) begin
            cnt <= '0;
            tick <= 1'b0;
        end else begin
            tick <= (cnt == LAST);                     // One pulse per wrap
            cnt <= (cnt == LAST) ? '0 : cnt + 1'b1;
        end
    end

    // A clock slower than 16x the baud rate cannot be divided down
    a_div_ratio: assert property (@(posedge Clk) DIV >= 1)
        else $error("uart_baud_tick: clock too slow for 16x oversampling");

endmodule

// File: design/uart_pkg.sv
package uart_pkg;

    // Frame defaults, the top level takes its parameters from these
    localparam int UART_DATA_BITS = 8;
    localparam int UART_STOP_BITS = 2;

    // Oversampling of each bit on the shared tick
    localparam int OVERSAMPLE = 16;
    localparam int PHASE_W = $clog2(OVERSAMPLE);  // Width of the tick phase counters
    localparam int MID_SAMPLE = 7;                // Phase at which a bit is taken, near its centre

    // Bit positions in the 3-bit receive error word
    localparam int ERR_BREAK = 0;   // Line held low for the whole frame
    localparam int ERR_PARITY = 1;  // Even parity mismatch
    localparam int ERR_FRAME = 2;   // A stop bit was sampled low

    // Widest data word the parity helper accepts
    localparam int PARITY_W = 16;

    // Even parity bit of a data word
    // Callers zero-extend narrower words, which leaves the XOR unchanged
    function automatic logic even_parity(input logic [PARITY_W-1:0] d);
        return ^d;
    endfunction

endpackage

// File: design/uart_rx.sv
`timescale 1ns/1ns

module uart_rx import uart_pkg::*; #(
    parameter int DATA_BITS = UART_DATA_BITS,
    parameter int STOP_BITS = UART_STOP_BITS
) (
    input  logic Clk,
    input  logic Rst,
    input  logic tick,
    input  logic rx_line,
    output logic rts,
    rx_frame_if.src frm
);

    // Start, data, parity and stop bits
    localparam int NUM_BITS = 1 + DATA_BITS + 1 + STOP_BITS;
    localparam int CNT_W = $clog2(NUM_BITS + 1);

    typedef enum logic [1:0] {
        IDLE,       // Waiting for a falling start edge
        RECEIVING,  // Sampling bits at mid-bit
        CHECK,      // Errors are evaluated and the frame is reported
        CLEANUP     // One spare cycle before the next start can be seen
    } rx_state_t;

    rx_state_t state;
    logic rx_meta;                      // First synchroniser stage
    logic rx_sync;                      // Line as seen by the FSM
    logic [PHASE_W-1:0] phase;          // Tick count inside the current bit
    logic [CNT_W-1:0] bits_left;        // Bits still to sample in this frame
    logic [NUM_BITS-1:0] frame_sr;      // Start bit ends up at the MSB, last stop bit at bit 0
    logic [DATA_BITS-1:0] rx_word;
    logic [2:0] err;
    logic sample;

    // Two flops against metastability, reset to the idle mark so no false start follows reset
    always_ff @(posedge Clk or posedge Rst) begin
        if (Rst) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
        end else begin
            rx_meta <= rx_line;
            rx_sync <= rx_meta;
        end
    end

    // Sampling point, tick phase 7 of every bit
    assign sample = (state == RECEIVING) && tick && (phase == PHASE_W'(MID_SAMPLE));

    // Data sits just below the start bit, MSB first on the line
    assign rx_word = frame_sr[NUM_BITS-2 -: DATA_BITS];

    // Error word from the completed frame
    always_comb begin
        err = '0;
        err[ERR_BREAK] = (frame_sr == '0);                                      // No mark seen at all
        err[ERR_PARITY] = frame_sr[STOP_BITS] != even_parity(PARITY_W'(rx_word));
        err[ERR_FRAME] = (frame_sr[STOP_BITS-1:0] != '1);                       // Any stop bit low
    end

    // Receive FSM
    always_ff @(posedge Clk or posedge Rst) begin
        if (Rst) begin
            state <= IDLE;
            rts <= 1'b1;              // Ready to receive right out of reset
            phase <= '0;
            bits_left <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (!rx_sync) begin                 // Falling edge of the start bit
                        state <= RECEIVING;
                        rts <= 1'b0;
                        phase <= '0;                    // Phase restarts from the edge
                        bits_left <= CNT_W'(NUM_BITS);
                    end
                end
                RECEIVING: begin
                    if (tick) begin
                        phase <= phase + 1'b1;          // Wraps every 16 ticks, one bit time
                    end
                    if (sample) begin
                        bits_left <= bits_left - 1'b1;
                        if (bits_left == CNT_W'(1)) begin
                            state <= CHECK;             // Last stop bit is in
                        end
                    end
                end
                CHECK: begin
                    state <= CLEANUP;
                end
                CLEANUP: begin
                    state <= IDLE;
                    rts <= 1'b1;                        // Idle again, next start may come
                end
                default: begin
                    state <= IDLE;
                    rts <= 1'b1;
                end
            endcase
        end
    end

    // Status strobes and the held error word
    always_ff @(posedge Clk or posedge Rst) begin
        if (Rst) begin
            frm.frame_done <= 1'b0;
            frm.data_rdy <= 1'b0;
            frm.rx_error <= '0;
        end else begin
            frm.frame_done <= (state == CHECK);                 // Every frame, good or bad
            frm.data_rdy <= (state == CHECK) && (err == '0);    // Only clean frames reach the FIFO
            if (state == CHECK) begin
                frm.rx_error <= err;                            // Held until the next frame ends
            end
        end
    end

    // Frame shift register and the output byte
    always_ff @(posedge Clk) begin
        if (sample) begin
            frame_sr <= {frame_sr[NUM_BITS-2:0], rx_sync};
        end
        if (state == CHECK) begin
            frm.data <= rx_word;        // Lines up with frame_done and rx_error
        end
    end

    // A byte is never offered outside the end of a frame
    a_rdy_in_done: assert property (@(posedge Clk) disable iff (Rst)
        frm.data_rdy |-> frm.frame_done)
        else $error("uart_rx: data_rdy without frame_done");

    // Ready-to-send must drop for the whole time a frame is in progress
    a_rts_busy: assert property (@(posedge Clk) disable iff (Rst)
        (state != IDLE) |-> !rts)
        else $error("uart_rx: rts high while receiving");

endmodule

// File: design/uart_rx_fifo.sv
`timescale 1ns/1ns

module uart_rx_fifo #(
    parameter int DATA_BITS = 8,
    parameter int DEPTH = 4
) (
    input  logic Clk,
    input  logic Rst,
    rx_frame_if.snk frm,
    input  logic rd_en,
    output logic [DATA_BITS-1:0] rd_data,
    output logic rd_empty,
    output logic overflow
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);
    localparam logic [PTR_W-1:0] PTR_LAST = PTR_W'(DEPTH - 1);

    logic [DATA_BITS-1:0] mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;          // Bytes currently stored
    logic full;
    logic push;
    logic pop;

    assign full = (count == CNT_W'(DEPTH));
    assign rd_empty = (count == '0);
    assign push = frm.data_rdy && !full;      // A byte arriving on a full FIFO is lost
    assign pop = rd_en && !rd_empty;
    assign rd_data = mem[rd_ptr];             // Head of the queue, no read latency

    // Pointers, occupancy and the sticky overflow flag
    always_ff @(posedge Clk or posedge Rst) begin
        if (Rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
            overflow <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_LAST) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_LAST) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;        // Both or neither leave it as is
            endcase
            if (frm.data_rdy && full) begin
                overflow <= 1'b1;               // Stays set until reset
            end
        end
    end

    // Storage
    always_ff @(posedge Clk) begin
        if (push) begin
            mem[wr_ptr] <= frm.data;
        end
    end

    a_count_bound: assert property (@(posedge Clk) disable iff (Rst)
        count <= CNT_W'(DEPTH))
        else $error("uart_rx_fifo: occupancy above depth");

endmodule

// File: design/uart_top.sv
`timescale 1ns/1ns

module uart_top import uart_pkg::*; #(
    parameter int DATA_BITS = UART_DATA_BITS,
    parameter int STOP_BITS = UART_STOP_BITS,
    parameter int CLK_FREQ = 3_200_000,
    parameter int BAUD_RATE = 100_000,
    parameter int FIFO_DEPTH = 4
) (
    input  logic Clk,
    input  logic Rst,
    input  logic rx_line,
    output logic rts,
    output logic [2:0] rx_error,
    output logic frame_done,
    input  logic rd_en,
    output logic [DATA_BITS-1:0] rd_data,
    output logic rd_empty,
    output logic overflow,
    input  logic [DATA_BITS-1:0] tx_data,
    input  logic tx_start,
    output logic tx_line,
    output logic tx_busy
);

    logic tick;   // Shared 16x oversampling pulse

    rx_frame_if #(.DATA_BITS(DATA_BITS)) frm_if ();

    uart_baud_tick #(.CLK_FREQ(CLK_FREQ), .BAUD_RATE(BAUD_RATE)) baud_tick_i (
        .Clk(Clk), .Rst(Rst), .tick(tick)
    );

    uart_rx #(.DATA_BITS(DATA_BITS), .STOP_BITS(STOP_BITS)) rx_i (
        .Clk(Clk), .Rst(Rst), .tick(tick), .rx_line(rx_line), .rts(rts), .frm(frm_if.src)
    );

    uart_rx_fifo #(.DATA_BITS(DATA_BITS), .DEPTH(FIFO_DEPTH)) rx_fifo_i (
        .Clk(Clk), .Rst(Rst), .frm(frm_if.snk), .rd_en(rd_en),
        .rd_data(rd_data), .rd_empty(rd_empty), .overflow(overflow)
    );

    uart_tx #(.DATA_BITS(DATA_BITS), .STOP_BITS(STOP_BITS)) tx_i (
        .Clk(Clk), .Rst(Rst), .tick(tick), .tx_data(tx_data), .tx_start(tx_start),
        .tx_line(tx_line), .tx_busy(tx_busy)
    );

    // Frame status straight out to the host
    assign rx_error = frm_if.rx_error;
    assign frame_done = frm_if.frame_done;

endmodule

// File: design/uart_tx.sv
`timescale 1ns/1ns

module uart_tx import uart_pkg::*; #(
    parameter int DATA_BITS = UART_DATA_BITS,
    parameter int STOP_BITS = UART_STOP_BITS
) (
    input  logic Clk,
    input  logic Rst,
    input  logic tick,
    input  logic [DATA_BITS-1:0] tx_data,
    input  logic tx_start,
    output logic tx_line,
    output logic tx_busy
);

    localparam int NUM_BITS = 1 + DATA_BITS + 1 + STOP_BITS;
    localparam int CNT_W = $clog2(NUM_BITS + 1);

    logic [PHASE_W-1:0] phase;        // Tick count inside the bit on the line
    logic [CNT_W-1:0] bits_left;      // Bits not yet finished, start bit included
    logic [NUM_BITS-2:0] tx_sr;       // Data, parity and stop bits waiting behind the line
    logic accept;
    logic bit_end;

    assign accept = tx_start && !tx_busy;     // A start while busy is dropped
    assign bit_end = tx_busy && tick && (phase == PHASE_W'(OVERSAMPLE - 1));

    // Transmit control, tx_line is registered so it never glitches
    always_ff @(posedge Clk or posedge Rst) begin
        if (Rst) begin
            tx_busy <= 1'b0;
            tx_line <= 1'b1;          // Idle mark
            phase <= '0;
            bits_left <= '0;
        end else begin
            if (!tx_busy) begin
                if (tx_start) begin
                    tx_busy <= 1'b1;
                    tx_line <= 1'b0;                    // Start bit goes out at once
                    phase <= '0;
                    bits_left <= CNT_W'(NUM_BITS);
                end
            end else begin
                if (tick) begin
                    phase <= phase + 1'b1;              // 16 ticks per bit
                end
                if (bit_end) begin
                    bits_left <= bits_left - 1'b1;
                    if (bits_left == CNT_W'(1)) begin
                        tx_busy <= 1'b0;                // Last stop bit has ended
                        tx_line <= 1'b1;
                    end else begin
                        tx_line <= tx_sr[NUM_BITS-2];   // Next bit, MSB of data first
                    end
                end
            end
        end
    end

    // Frame body, loaded on accept and shifted at every bit boundary
    always_ff @(posedge Clk) begin
        if (accept) begin
            tx_sr <= {tx_data, even_parity(PARITY_W'(tx_data)), {STOP_BITS{1'b1}}};
        end else if (bit_end) begin
            tx_sr <= {tx_sr[NUM_BITS-3:0], 1'b1};       // Mark fills in behind
        end
    end

    // Line must sit at mark between frames
    a_idle_mark: assert property (@(posedge Clk) disable iff (Rst)
        !tx_busy |-> tx_line)
        else $error("uart_tx: line low while not busy");

endmodule

// File: run_sim.sh
#!/bin/sh
# Builds the UART testbench with Verilator, runs it and looks for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -j 0 --top-module tb_uart -f uart.f || exit 1
out=$(./obj_dir/Vtb_uart)
echo "$out"
echo "$out" | grep -qx "TEST PASS" && exit 0 || exit 1

// File: sim/tb_uart.sv
`timescale 1ns/1ns

module tb_uart import uart_pkg::*; ();

    localparam int DATA_BITS = 8;
    localparam int STOP_BITS = 2;
    localparam int FIFO_DEPTH = 4;
    localparam int NUM_BITS = 1 + DATA_BITS + 1 + STOP_BITS;
    localparam int BIT_CLKS = 32;                       // 3.2 MHz clock over 100 kbaud
    localparam int FRAME_CLKS = NUM_BITS * BIT_CLKS;

    logic Clk = 1'b0;
    logic Rst;
    logic rx_drv;                   // Serial line as driven by the testbench
    logic loop_en;                  // Routes tx_line back into the receiver
    logic rx_line;
    logic rts;
    logic [2:0] rx_error;
    logic frame_done;
    logic rd_en;
    logic [DATA_BITS-1:0] rd_data;
    logic rd_empty;
    logic overflow;
    logic [DATA_BITS-1:0] tx_data;
    logic tx_start;
    logic tx_line;
    logic tx_busy;
    logic [2:0] err_log[$];         // Error word of every frame_done, oldest first
    int pat_mode[$];
    int pat_data[$];
    int pat_err[$];
    int n_errors = 0;
    int n_checks = 0;
    int cycles = 0;
    int cycle_limit = 0;            // Set once the pattern count is known
    int seed = 32'h3f960caf;

    assign rx_line = loop_en ? tx_line : rx_drv;

    uart_top #(
        .DATA_BITS(DATA_BITS), .STOP_BITS(STOP_BITS), .CLK_FREQ(3_200_000),
        .BAUD_RATE(100_000), .FIFO_DEPTH(FIFO_DEPTH)
    ) uart_top_i (
        .Clk(Clk), .Rst(Rst), .rx_line(rx_line), .rts(rts), .rx_error(rx_error),
        .frame_done(frame_done), .rd_en(rd_en), .rd_data(rd_data), .rd_empty(rd_empty),
        .overflow(overflow), .tx_data(tx_data), .tx_start(tx_start), .tx_line(tx_line),
        .tx_busy(tx_busy)
    );

    always #50 Clk = ~Clk;

    // Frame status is sampled on the falling edge, half a cycle after it settles
    always @(negedge Clk) begin
        if (frame_done) begin
            err_log.push_back(rx_error);
        end
    end

    // Watchdog on the whole run
    always @(negedge Clk) begin
        cycles++;
        if (cycle_limit > 0 && cycles > cycle_limit) begin
            $display("Timeout, the tests did not finish within %0d clock cycles", cycle_limit);
            $display("Checks: %0d, errors: %0d", n_checks, n_errors + 1);
            $display("TEST FAIL");
            $finish;
        end
    end

    task automatic compare_value(input string name, input int exp, input int act);
        n_checks++;
        if (exp != act) begin
            n_errors++;
            $display("ERR %s: expected %0h, actual %0h", name, exp, act);
        end
    endtask

    // Error word that a frame must produce, bit 11 is the start bit
    function automatic logic [2:0] frame_errors(input logic [NUM_BITS-1:0] bits);
        logic [2:0] e;
        e = '0;
        e[ERR_BREAK] = (bits == '0);
        e[ERR_PARITY] = bits[STOP_BITS] != ^bits[NUM_BITS-2:STOP_BITS+1];  // Even parity
        e[ERR_FRAME] = bits[STOP_BITS-1:0] != {STOP_BITS{1'b1}};
        return e;
    endfunction

    // Drives one frame on rx_line, MSB of bits first, one bit per 32 clocks
    task automatic send_frame(input string name, input logic [NUM_BITS-1:0] bits);
        for (int i = NUM_BITS - 1; i >= 0; i--) begin
            if (i == NUM_BITS - 1) begin
                compare_value({name, " rts before start bit"}, 1, int'(rts));
            end
            if (i == NUM_BITS - 2) begin
                compare_value({name, " rts during frame"}, 0, int'(rts));   // Start has been seen
            end
            rx_drv = bits[i];
            repeat (BIT_CLKS) @(negedge Clk);
        end
        rx_drv = 1'b1;
    endtask

    task automatic check_frame(input string name, input int base, input logic [2:0] exp_err);
        while (err_log.size() <= base) @(negedge Clk);
        @(negedge Clk);                                      // FIFO takes the byte after frame_done
        // Exactly one strobe for this frame
        compare_value({name, " frame_done pulses"}, base + 1, err_log.size());
        compare_value({name, " rx_error"}, int'(exp_err), int'(err_log[base]));
    endtask

    task automatic pop_and_check(input string name, input logic [7:0] exp);
        compare_value({name, " rd_empty"}, 0, int'(rd_empty));
        compare_value({name, " rd_data"}, int'(exp), int'(rd_data));
        rd_en = 1'b1;
        @(negedge Clk);
        rd_en = 1'b0;
    endtask

    task automatic run_rx_test(input string name, input int mode, input logic [7:0] data,
                               input int file_err);
        logic [NUM_BITS-1:0] bits;
        int base;
        bits = {1'b0, data, ^data, {STOP_BITS{1'b1}}};
        case (mode)
            1: bits[STOP_BITS] = ~bits[STOP_BITS];       // Wrong parity bit
            2: bits[STOP_BITS-1] = 1'b0;                 // First stop bit low, last one high
            3: bits = '0;                                // Break
            default: ;
        endcase
        compare_value({name, " pattern flags"}, int'(frame_errors(bits)), file_err);
        base = err_log.size();
        send_frame(name, bits);
        check_frame(name, base, frame_errors(bits));
        if (frame_errors(bits) == '0) begin
            pop_and_check(name, data);
        end else begin
            compare_value({name, " rd_empty"}, 1, int'(rd_empty));
        end
        // The low tail of a break reads as a new start bit, so that frame runs out first
        if (mode == 3) begin
            while (!rts) @(negedge Clk);
        end
    endtask

    task automatic run_loopback(input string name, input logic [7:0] data);
        int base;
        int busy_clks;
        base = err_log.size();
        busy_clks = 0;
        loop_en = 1'b1;
        tx_data = data;
        tx_start = 1'b1;
        @(negedge Clk);
        tx_start = 1'b0;
        compare_value({name, " tx_busy after start"}, 1, int'(tx_busy));
        while (tx_busy) begin
            busy_clks++;
            @(negedge Clk);
        end
        // One tick of start phase either way is allowed
        compare_value({name, " tx_busy clocks"}, FRAME_CLKS,
            (busy_clks >= FRAME_CLKS - 2 && busy_clks <= FRAME_CLKS + 2) ? FRAME_CLKS : busy_clks);
        check_frame(name, base, 3'b000);
        pop_and_check(name, data);
        loop_en = 1'b0;
    endtask

    task automatic run_overflow(input string name, input logic [7:0] first);
        logic [7:0] sent[FIFO_DEPTH+1];
        int base;
        for (int k = 0; k <= FIFO_DEPTH; k++) begin
            sent[k] = (k == 0) ? first : 8'($random(seed));
            base = err_log.size();
            send_frame(name, {1'b0, sent[k], ^sent[k], {STOP_BITS{1'b1}}});
            check_frame(name, base, 3'b000);
        end
        compare_value({name, " overflow"}, 1, int'(overflow));
        for (int k = 0; k < FIFO_DEPTH; k++) begin
            pop_and_check(name, sent[k]);                // Last byte of the burst was dropped
        end
        compare_value({name, " rd_empty at end"}, 1, int'(rd_empty));
    endtask

    initial begin
        int fd;
        int m;
        int d;
        int e;
        logic [8*128-1:0] line;
        Rst = 1'b1;
        rx_drv = 1'b1;
        loop_en = 1'b0;
        rd_en = 1'b0;
        tx_data = '0;
        tx_start = 1'b0;
        fd = $fopen("sim/uart_patterns.txt", "r");
        if (fd == 0) begin
            n_errors++;
            $display("Could not open the pattern file sim/uart_patterns.txt");
        end else begin
            line = '0;
            while ($fgets(line, fd) != 0) begin
                if ($sscanf(line, "%h %h %h", m, d, e) == 3) begin   // Comment lines give no field
                    pat_mode.push_back(m);
                    pat_data.push_back(d);
                    pat_err.push_back(e);
                end
                line = '0;
            end
            $fclose(fd);
        end
        cycle_limit = pat_mode.size() * 2 * 400 + 2000;
        repeat (4) @(negedge Clk);
        Rst = 1'b0;
        @(negedge Clk);
        compare_value("reset rts", 1, int'(rts));
        compare_value("reset tx_line", 1, int'(tx_line));
        compare_value("reset rd_empty", 1, int'(rd_empty));
        compare_value("reset tx_busy", 0, int'(tx_busy));
        compare_value("reset overflow", 0, int'(overflow));
        compare_value("reset frame_done", 0, int'(frame_done));
        compare_value("reset rx_error", 0, int'(rx_error));
        foreach (pat_mode[i]) begin
            string name;
            name = $sformatf("pattern %0d mode %0d byte %02h", i, pat_mode[i], pat_data[i]);
            if (pat_mode[i] >= 4) begin
                compare_value({name, " pattern flags"}, 0, pat_err[i]);  // Always a clean frame
            end
            case (pat_mode[i])
                0, 1, 2, 3: run_rx_test(name, pat_mode[i], 8'(pat_data[i]), pat_err[i]);
                4: run_loopback(name, 8'(pat_data[i]));
                5: run_overflow(name, 8'(pat_data[i]));
                default: begin
                    n_errors++;
                    $display("Unknown test mode %0d in %s", pat_mode[i], name);
                end
            endcase
        end
        repeat (4) @(negedge Clk);
        $display("Checks: %0d, errors: %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// File: sim/uart_patterns.txt
# mode: 0 good, 1 bad parity, 2 bad stop, 3 break, 4 loopback, 5 overflow burst
# then data byte and expected rx_error (bit 0 break, 1 parity, 2 frame), all hex
0 a5 0
0 00 0
0 ff 0
1 3c 2
2 81 4
3 00 5
0 5a 0
4 c3 0
4 01 0
5 96 0

// File: uart.f
design/uart_pkg.sv
design/rx_frame_if.sv
design/uart_baud_tick.sv
design/uart_rx.sv
design/uart_tx.sv
design/uart_rx_fifo.sv
design/uart_top.sv
sim/tb_uart.sv
